// File: Makefile
VERILATOR ?= verilator
TOP       ?= rf_toplevel_tb
FILELIST  ?= rf_toplevel.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/pcs_frame_gen.sv
`timescale 1ns/1ns
`default_nettype none
`include "rf_params.svh"

module pcs_frame_gen (
    input  wire                 i_clock,
    input  wire                 i_rst,
    input  wire                 i_enable,
    output pcs_pkg::pcs_block_t o_block,
    output logic                o_valid
);

    localparam int NB_PAYLOAD = `PCS_NB_BLOCK - 2;

    logic [NB_PAYLOAD-1:0] payload_cnt;

    // Counter holds its value while disabled
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            payload_cnt <= '0;
            o_valid     <= 1'b0;
        end else begin
            o_valid <= i_enable;
            if (i_enable) begin
                payload_cnt <= payload_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_enable) begin
            o_block <= {pcs_pkg::SH_DATA, payload_cnt};
        end
    end

endmodule

`default_nettype wire

// File: design/pcs_pkg.sv
`default_nettype none
`include "rf_params.svh"

package pcs_pkg;

    // Sync header sits in the two top bits of a block
    typedef logic [`PCS_NB_BLOCK-1:0]   pcs_block_t;
    typedef logic [1:0]                 pcs_sh_t;

    localparam pcs_sh_t SH_DATA = 2'b01;
    localparam pcs_sh_t SH_CTRL = 2'b10;
    localparam pcs_sh_t SH_BAD  = 2'b00;

    typedef enum logic [1:0] {
        BRK_OFF      = 2'd0,
        BRK_ALWAYS   = 2'd1,
        BRK_PERIODIC = 2'd2
    } brk_mode_e;

    typedef enum logic {
        ST_UNLOCKED = 1'b0,
        ST_LOCKED   = 1'b1
    } lock_state_e;

    typedef logic [`PCS_NB_CNT-1:0]     brk_cnt_t;
    typedef logic [`PCS_NB_ERR_CNT-1:0] err_cnt_t;

endpackage

`default_nettype wire

// File: design/pcs_sh_breaker.sv
`timescale 1ns/1ns
`default_nettype none
`include "rf_params.svh"

module pcs_sh_breaker (
    input  wire                         i_clock,
    input  wire                         i_rst,
    input  wire                         i_update,
    input  wire pcs_pkg::brk_mode_e     i_mode,
    input  wire pcs_pkg::brk_cnt_t      i_burst,
    input  wire pcs_pkg::brk_cnt_t      i_period,
    input  wire pcs_pkg::pcs_block_t    i_block,
    input  wire                         i_valid,
    output pcs_pkg::pcs_block_t         o_block,
    output logic                        o_valid
);

    pcs_pkg::brk_mode_e mode_q;
    pcs_pkg::brk_cnt_t  burst_q;
    pcs_pkg::brk_cnt_t  period_q;
    pcs_pkg::brk_cnt_t  phase;
    logic               corrupt;

    always_comb begin
        corrupt = 1'b0;
        if (i_valid) begin
            case (mode_q)
                pcs_pkg::BRK_ALWAYS: begin
                    corrupt = 1'b1;
                end
                // Zero period disables periodic breaking
                pcs_pkg::BRK_PERIODIC: begin
                    corrupt = (period_q != '0) && (phase < burst_q);
                end
                default: begin
                    corrupt = 1'b0;
                end
            endcase
        end
    end

    // Config load and phase restart on update
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            mode_q   <= pcs_pkg::BRK_OFF;
            burst_q  <= '0;
            period_q <= '0;
            phase    <= '0;
        end else if (i_update) begin
            mode_q   <= i_mode;
            burst_q  <= i_burst;
            period_q <= i_period;
            phase    <= '0;
        end else if (i_valid) begin
            if (phase >= period_q - 1'b1) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Payload passes untouched
    always_ff @(posedge i_clock) begin
        if (corrupt) begin
            o_block <= {pcs_pkg::SH_BAD, i_block[`PCS_NB_BLOCK-3:0]};
        end else begin
            o_block <= i_block;
        end
    end

endmodule

`default_nettype wire

// File: design/pcs_sh_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "rf_params.svh"

module pcs_sh_checker (
    input  wire                         i_clock,
    input  wire                         i_rst,
    input  wire                         i_enable,
    input  wire [`PCS_NB_INVALID-1:0]   i_inv_limit,
    input  wire                         i_cor,
    input  wire pcs_pkg::pcs_block_t    i_block,
    input  wire                         i_valid,
    output logic                        o_block_lock,
    output pcs_pkg::err_cnt_t           o_err_snapshot
);

    localparam int NB_GOOD = $clog2(`PCS_LOCK_GOOD + 1);
    localparam int NB_WIN  = $clog2(`PCS_WINDOW);
    localparam int NB_INV  = `PCS_NB_INVALID;

    pcs_pkg::lock_state_e   state;
    logic [NB_GOOD-1:0]     good_cnt;
    logic [NB_WIN-1:0]      win_cnt;
    logic [NB_INV-1:0]      inv_cnt;
    logic [NB_INV:0]        inv_next;
    pcs_pkg::pcs_sh_t       sh;
    pcs_pkg::err_cnt_t      err_cnt;
    logic                   sh_ok;
    logic                   blk;
    logic                   inv_hit;
    logic                   lose_lock;

    assign sh        = i_block[`PCS_NB_BLOCK-1 -: 2];
    assign sh_ok     = (sh == pcs_pkg::SH_DATA) || (sh == pcs_pkg::SH_CTRL);
    assign blk       = i_valid & i_enable;
    assign inv_hit   = blk & ~sh_ok;
    assign inv_next  = {1'b0, inv_cnt} + (NB_INV + 1)'(inv_hit);
    // Limit of zero never drops lock
    assign lose_lock = (i_inv_limit != '0) && (inv_next >= {1'b0, i_inv_limit});

    assign o_block_lock = (state == pcs_pkg::ST_LOCKED);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state    <= pcs_pkg::ST_UNLOCKED;
            good_cnt <= '0;
            win_cnt  <= '0;
            inv_cnt  <= '0;
        end else if (blk) begin
            case (state)
                pcs_pkg::ST_UNLOCKED: begin
                    if (!sh_ok) begin
                        good_cnt <= '0;
                    end else if (good_cnt == NB_GOOD'(`PCS_LOCK_GOOD - 1)) begin
                        state    <= pcs_pkg::ST_LOCKED;
                        good_cnt <= '0;
                        win_cnt  <= '0;
                        inv_cnt  <= '0;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end
                pcs_pkg::ST_LOCKED: begin
                    if (lose_lock) begin
                        state   <= pcs_pkg::ST_UNLOCKED;
                        win_cnt <= '0;
                        inv_cnt <= '0;
                    end else if (win_cnt == NB_WIN'(`PCS_WINDOW - 1)) begin
                        // Window closed, start a fresh count
                        win_cnt <= '0;
                        inv_cnt <= '0;
                    end else begin
                        win_cnt <= win_cnt + 1'b1;
                        inv_cnt <= inv_next[NB_INV-1:0];
                    end
                end
                default: begin
                    state <= pcs_pkg::ST_UNLOCKED;
                end
            endcase
        end
    end

    // Clear-on-read keeps a header seen in the same cycle
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            err_cnt        <= '0;
            o_err_snapshot <= '0;
        end else if (i_cor) begin
            o_err_snapshot <= err_cnt;
            err_cnt        <= pcs_pkg::err_cnt_t'(inv_hit);
        end else if (inv_hit && (err_cnt != '1)) begin
            err_cnt <= err_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/rf_params.svh
`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// GPIO word layout
`define RF_NB_GPIO      32
`define RF_NB_ADDR      9
`define RF_NB_DATA      22
`define RF_ENABLE_BIT   31

// PCS block and breaker widths
`define PCS_NB_BLOCK    66
`define PCS_NB_CNT      10
`define PCS_NB_ERR_CNT  16

// Block lock thresholds
`define PCS_LOCK_GOOD   64
`define PCS_WINDOW      64
`define PCS_NB_INVALID  6

`endif

// File: design/rf_pkg.sv
`default_nettype none
`include "rf_params.svh"

package rf_pkg;

    typedef logic [`RF_NB_GPIO-1:0] gpio_t;
    typedef logic [`RF_NB_ADDR-1:0] rf_addr_t;
    typedef logic [`RF_NB_DATA-1:0] rf_data_t;

    // Write registers sit in the low page, status in the upper page
    typedef enum logic [`RF_NB_ADDR-1:0] {
        ADDR_CTRL       = 9'h000,
        ADDR_BRK_MODE   = 9'h001,
        ADDR_BRK_BURST  = 9'h002,
        ADDR_BRK_PERIOD = 9'h003,
        ADDR_INV_LIMIT  = 9'h004,
        ADDR_COR_ERR    = 9'h005,
        ADDR_STATUS     = 9'h100,
        ADDR_ERR_COUNT  = 9'h101
    } rf_addr_e;

    // CTRL register bits
    localparam int CTRL_SOFT_RST = 0;
    localparam int CTRL_GEN_EN   = 1;
    localparam int CTRL_CHK_EN   = 2;

    // STATUS register bits
    localparam int STATUS_LOCK   = 0;

endpackage

`default_nettype wire

// File: design/rf_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

module rf_read_mux (
    input  wire                     i_clock,
    input  wire                     i_rst,
    input  wire rf_pkg::rf_addr_t   i_addr,
    input  wire                     i_block_lock,
    input  wire pcs_pkg::err_cnt_t  i_err_snapshot,
    output rf_pkg::gpio_t           o_gpio_data
);

    rf_pkg::gpio_t status_word;

    always_comb begin
        status_word = '0;
        status_word[rf_pkg::STATUS_LOCK] = i_block_lock;
    end

    // One cycle behind the address, unknown addresses read zero
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_gpio_data <= '0;
        end else begin
            case (rf_pkg::rf_addr_e'(i_addr))
                rf_pkg::ADDR_STATUS: begin
                    o_gpio_data <= status_word;
                end
                rf_pkg::ADDR_ERR_COUNT: begin
                    o_gpio_data <= rf_pkg::gpio_t'(i_err_snapshot);
                end
                default: begin
                    o_gpio_data <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rf_toplevel.sv
`timescale 1ns/1ns
`default_nettype none
`include "rf_params.svh"

module rf_toplevel (
    input  wire                 i_clock,
    input  wire                 i_rst,
    input  wire rf_pkg::gpio_t  i_gpio_data,
    output rf_pkg::gpio_t       o_gpio_data
);

    logic                           rf_enable;
    rf_pkg::rf_addr_t               rf_addr;
    rf_pkg::rf_data_t               rf_data;

    logic                           soft_rst;
    logic                           pipe_rst;
    logic                           gen_enable;
    logic                           chk_enable;
    logic                           brk_update;
    pcs_pkg::brk_mode_e             brk_mode;
    pcs_pkg::brk_cnt_t              brk_burst;
    pcs_pkg::brk_cnt_t              brk_period;
    logic [`PCS_NB_INVALID-1:0]     inv_limit;
    logic                           cor_err;

    pcs_pkg::pcs_block_t            gen_block;
    logic                           gen_valid;
    pcs_pkg::pcs_block_t            brk_block;
    logic                           brk_valid;
    logic                           block_lock;
    pcs_pkg::err_cnt_t              err_snapshot;

    // GPIO word is enable, address, data from MSB down
    assign rf_enable = i_gpio_data[`RF_ENABLE_BIT];
    assign rf_addr   = i_gpio_data[`RF_ENABLE_BIT-1 -: `RF_NB_ADDR];
    assign rf_data   = i_gpio_data[`RF_NB_DATA-1:0];

    assign pipe_rst  = i_rst | soft_rst;

    rf_write u_rf_write (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_enable     (rf_enable),
        .i_addr       (rf_addr),
        .i_data       (rf_data),
        .o_soft_rst   (soft_rst),
        .o_gen_enable (gen_enable),
        .o_chk_enable (chk_enable),
        .o_brk_update (brk_update),
        .o_brk_mode   (brk_mode),
        .o_brk_burst  (brk_burst),
        .o_brk_period (brk_period),
        .o_inv_limit  (inv_limit),
        .o_cor_err    (cor_err)
    );

    rf_read_mux u_rf_read_mux (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_addr         (rf_addr),
        .i_block_lock   (block_lock),
        .i_err_snapshot (err_snapshot),
        .o_gpio_data    (o_gpio_data)
    );

    pcs_frame_gen u_pcs_frame_gen (
        .i_clock  (i_clock),
        .i_rst    (pipe_rst),
        .i_enable (gen_enable),
        .o_block  (gen_block),
        .o_valid  (gen_valid)
    );

    pcs_sh_breaker u_pcs_sh_breaker (
        .i_clock  (i_clock),
        .i_rst    (pipe_rst),
        .i_update (brk_update),
        .i_mode   (brk_mode),
        .i_burst  (brk_burst),
        .i_period (brk_period),
        .i_block  (gen_block),
        .i_valid  (gen_valid),
        .o_block  (brk_block),
        .o_valid  (brk_valid)
    );

    pcs_sh_checker u_pcs_sh_checker (
        .i_clock        (i_clock),
        .i_rst          (pipe_rst),
        .i_enable       (chk_enable),
        .i_inv_limit    (inv_limit),
        .i_cor          (cor_err),
        .i_block        (brk_block),
        .i_valid        (brk_valid),
        .o_block_lock   (block_lock),
        .o_err_snapshot (err_snapshot)
    );

endmodule

`default_nettype wire

// File: design/rf_write.sv
`timescale 1ns/1ns
`default_nettype none
`include "rf_params.svh"

module rf_write (
    input  wire                         i_clock,
    input  wire                         i_rst,
    input  wire                         i_enable,
    input  wire rf_pkg::rf_addr_t       i_addr,
    input  wire rf_pkg::rf_data_t       i_data,
    output logic                        o_soft_rst,
    output logic                        o_gen_enable,
    output logic                        o_chk_enable,
    output logic                        o_brk_update,
    output pcs_pkg::brk_mode_e          o_brk_mode,
    output pcs_pkg::brk_cnt_t           o_brk_burst,
    output pcs_pkg::brk_cnt_t           o_brk_period,
    output logic [`PCS_NB_INVALID-1:0]  o_inv_limit,
    output logic                        o_cor_err
);

    logic enable_q;
    logic wr_stb;

    // Write fires once per rising edge of the enable bit
    assign wr_stb = i_enable & ~enable_q;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            enable_q     <= 1'b0;
            o_soft_rst   <= 1'b0;
            o_gen_enable <= 1'b0;
            o_chk_enable <= 1'b0;
            o_brk_update <= 1'b0;
            o_brk_mode   <= pcs_pkg::BRK_OFF;
            o_brk_burst  <= '0;
            o_brk_period <= '0;
            o_inv_limit  <= '0;
            o_cor_err    <= 1'b0;
        end else begin
            enable_q     <= i_enable;
            o_brk_update <= 1'b0;
            o_cor_err    <= 1'b0;
            if (wr_stb) begin
                case (rf_pkg::rf_addr_e'(i_addr))
                    rf_pkg::ADDR_CTRL: begin
                        o_soft_rst   <= i_data[rf_pkg::CTRL_SOFT_RST];
                        o_gen_enable <= i_data[rf_pkg::CTRL_GEN_EN];
                        o_chk_enable <= i_data[rf_pkg::CTRL_CHK_EN];
                    end
                    // Mode write also commits burst and period to the breaker
                    rf_pkg::ADDR_BRK_MODE: begin
                        o_brk_mode   <= pcs_pkg::brk_mode_e'(i_data[1:0]);
                        o_brk_update <= 1'b1;
                    end
                    rf_pkg::ADDR_BRK_BURST: begin
                        o_brk_burst <= i_data[`PCS_NB_CNT-1:0];
                    end
                    rf_pkg::ADDR_BRK_PERIOD: begin
                        o_brk_period <= i_data[`PCS_NB_CNT-1:0];
                    end
                    rf_pkg::ADDR_INV_LIMIT: begin
                        o_inv_limit <= i_data[`PCS_NB_INVALID-1:0];
                    end
                    rf_pkg::ADDR_COR_ERR: begin
                        o_cor_err <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rf_toplevel.f
+incdir+design
design/rf_pkg.sv
design/pcs_pkg.sv
design/rf_write.sv
design/rf_read_mux.sv
design/pcs_frame_gen.sv
design/pcs_sh_breaker.sv
design/pcs_sh_checker.sv
design/rf_toplevel.sv
verif/rf_toplevel_assertions.sv
verif/rf_toplevel_tb.sv

// File: verif/rf_toplevel_assertions.sv
`timescale 1ns/1ns
`default_nettype none
`include "rf_params.svh"

module rf_toplevel_assertions #(
    parameter bit CHECK_HEADER = 1'b1,
    parameter bit CHECK_LOCK   = 1'b0
) (
    input wire                      i_clock,
    input wire                      i_rst,
    input wire                      i_valid,
    input wire                      i_count_en,
    input wire pcs_pkg::pcs_block_t i_block,
    input wire pcs_pkg::brk_mode_e  i_mode,
    input wire                      i_lock
);

    int unsigned      valid_seen;
    pcs_pkg::pcs_sh_t sh;

    assign sh = i_block[`PCS_NB_BLOCK-1 -: 2];

    // Valid blocks since reset, saturating at the lock threshold
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            valid_seen <= 0;
        end else if (i_valid && i_count_en && (valid_seen < `PCS_LOCK_GOOD)) begin
            valid_seen <= valid_seen + 1;
        end
    end

    valid_low_after_reset: assert property (@(posedge i_clock) i_rst |=> !i_valid)
        else $error("valid seen high right after a reset cycle");

    // Mode of the previous cycle decided the header now at the output
    off_mode_keeps_header: assert property (@(posedge i_clock) disable iff (i_rst)
        CHECK_HEADER && i_valid && ($past(i_mode) == pcs_pkg::BRK_OFF)
        |-> ((sh == pcs_pkg::SH_DATA) || (sh == pcs_pkg::SH_CTRL)))
        else $error("invalid sync header while the breaker is off");

    lock_needs_good_blocks: assert property (@(posedge i_clock) disable iff (i_rst)
        CHECK_LOCK && $rose(i_lock) |-> (valid_seen >= `PCS_LOCK_GOOD))
        else $error("block lock rose before enough valid blocks");

endmodule

bind pcs_sh_breaker rf_toplevel_assertions #(
    .CHECK_HEADER (1'b1),
    .CHECK_LOCK   (1'b0)
) breaker_assertions_i (
    .i_clock    (i_clock),
    .i_rst      (i_rst),
    .i_valid    (o_valid),
    .i_count_en (1'b1),
    .i_block    (o_block),
    .i_mode     (mode_q),
    .i_lock     (1'b0)
);

bind pcs_sh_checker rf_toplevel_assertions #(
    .CHECK_HEADER (1'b0),
    .CHECK_LOCK   (1'b1)
) checker_assertions_i (
    .i_clock    (i_clock),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .i_count_en (i_enable),
    .i_block    (i_block),
    .i_mode     (pcs_pkg::BRK_OFF),
    .i_lock     (o_block_lock)
);

`default_nettype wire

// File: verif/rf_toplevel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rf_toplevel_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int SEED          = 19078;
    // Rounded-up block count of all tests plus room for register traffic
    localparam int TOTAL_BLOCKS  = 1100;
    localparam int MARGIN_CYCLES = 1500;
    localparam int WATCHDOG_NS   = (TOTAL_BLOCKS + MARGIN_CYCLES) * CLK_PERIOD;

    localparam rf_pkg::rf_data_t CTRL_RUN =
        rf_pkg::rf_data_t'((1 << rf_pkg::CTRL_GEN_EN) | (1 << rf_pkg::CTRL_CHK_EN));
    localparam rf_pkg::rf_data_t CTRL_CHK  = rf_pkg::rf_data_t'(1 << rf_pkg::CTRL_CHK_EN);
    localparam rf_pkg::rf_data_t CTRL_SOFT = rf_pkg::rf_data_t'(1 << rf_pkg::CTRL_SOFT_RST);

    logic          clk;
    logic          rst;
    rf_pkg::gpio_t gpio_in;
    rf_pkg::gpio_t gpio_out;

    // Pending read handed to the compare process
    logic          cmp_req;
    string         cmp_name;
    logic [31:0]   cmp_exp;

    rf_toplevel rf_toplevel_i (
        .i_clock     (clk),
        .i_rst       (rst),
        .i_gpio_data (gpio_in),
        .o_gpio_data (gpio_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int expected_errors(input pcs_pkg::brk_mode_e mode, input int burst,
                                           input int period, input int n_blocks);
        int errors;
        errors = 0;
        for (int i = 0; i < n_blocks; i++) begin
            case (mode)
                pcs_pkg::BRK_ALWAYS: begin
                    errors++;
                end
                pcs_pkg::BRK_PERIODIC: begin
                    if ((period != 0) && ((i % period) < burst)) begin
                        errors++;
                    end
                end
                default: begin
                end
            endcase
        end
        return (errors > 65535) ? 65535 : errors;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Register write lands on the last edge of this task
    task automatic gpio_write(input rf_pkg::rf_addr_t addr, input rf_pkg::rf_data_t data);
        @(posedge clk);
        gpio_in <= {1'b0, addr, data};
        @(posedge clk);
        gpio_in <= {1'b1, addr, data};
        @(posedge clk);
        gpio_in <= {1'b0, addr, data};
    endtask

    task automatic gpio_read_check(input rf_pkg::rf_addr_t addr, input string name,
                                   input logic [31:0] exp);
        @(posedge clk);
        gpio_in <= {1'b0, addr, rf_pkg::rf_data_t'(0)};
        repeat (2) @(posedge clk);
        cmp_name = name;
        cmp_exp  = exp;
        cmp_req  = 1'b1;
        wait (cmp_req == 1'b0);
    endtask

    task automatic set_breaker(input pcs_pkg::brk_mode_e mode, input int burst, input int period);
        gpio_write(rf_pkg::ADDR_BRK_BURST, rf_pkg::rf_data_t'(burst));
        gpio_write(rf_pkg::ADDR_BRK_PERIOD, rf_pkg::rf_data_t'(period));
        gpio_write(rf_pkg::ADDR_BRK_MODE, rf_pkg::rf_data_t'(mode));
    endtask

    // Generator runs for exactly n_blocks cycles while the checker keeps running
    task automatic run_blocks(input int n_blocks);
        gpio_write(rf_pkg::ADDR_CTRL, CTRL_RUN);
        repeat (n_blocks - 3) @(posedge clk);
        gpio_write(rf_pkg::ADDR_CTRL, CTRL_CHK);
        repeat (4) @(posedge clk);
    endtask

    task automatic clear_errors();
        gpio_write(rf_pkg::ADDR_COR_ERR, '0);
    endtask

    always @(negedge clk) begin
        if (cmp_req) begin
            check_value(cmp_name, gpio_out, cmp_exp);
            cmp_req = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int period;
        int burst;
        int n_blk;
        void'($urandom(SEED));
        clk      = 1'b0;
        rst      = 1'b1;
        gpio_in  = '0;
        cmp_req  = 1'b0;
        cmp_name = "";
        cmp_exp  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        gpio_read_check(rf_pkg::ADDR_STATUS, "o_gpio_data(status)", 32'd0);
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)", 32'd0);

        // Clean traffic reaches lock
        run_blocks(100);
        gpio_read_check(rf_pkg::ADDR_STATUS, "o_gpio_data(status)", 32'd1);
        clear_errors();
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)", 32'd0);

        for (int i = 0; i < 3; i++) begin
            period = 1 + ($urandom % 64);
            burst  = $urandom % (period + 1);
            n_blk  = 20 + ($urandom % 200);
            set_breaker(pcs_pkg::BRK_PERIODIC, burst, period);
            run_blocks(n_blk);
            clear_errors();
            gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)",
                            expected_errors(pcs_pkg::BRK_PERIODIC, burst, period, n_blk));
        end

        // Relock before breaking every header with an invalid limit of 4
        gpio_write(rf_pkg::ADDR_INV_LIMIT, rf_pkg::rf_data_t'(4));
        set_breaker(pcs_pkg::BRK_OFF, 0, 0);
        run_blocks(80);
        gpio_read_check(rf_pkg::ADDR_STATUS, "o_gpio_data(status)", 32'd1);
        clear_errors();
        set_breaker(pcs_pkg::BRK_ALWAYS, 0, 0);
        run_blocks(40);
        clear_errors();
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)",
                        expected_errors(pcs_pkg::BRK_ALWAYS, 0, 0, 40));
        gpio_read_check(rf_pkg::ADDR_STATUS, "o_gpio_data(status)", 32'd0);

        clear_errors();
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)", 32'd0);

        set_breaker(pcs_pkg::BRK_OFF, 0, 0);
        run_blocks(80);
        gpio_read_check(rf_pkg::ADDR_STATUS, "o_gpio_data(status)", 32'd1);
        set_breaker(pcs_pkg::BRK_PERIODIC, 1, 8);
        run_blocks(8);
        clear_errors();
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)",
                        expected_errors(pcs_pkg::BRK_PERIODIC, 1, 8, 8));
        run_blocks(8);
        gpio_read_check(rf_pkg::ADDR_STATUS, "o_gpio_data(status)", 32'd1);

        // Soft reset drops lock and both counters
        gpio_write(rf_pkg::ADDR_CTRL, CTRL_SOFT);
        gpio_write(rf_pkg::ADDR_CTRL, CTRL_CHK);
        gpio_read_check(rf_pkg::ADDR_STATUS, "o_gpio_data(status)", 32'd0);
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)", 32'd0);
        clear_errors();
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)", 32'd0);

        // Breaker is back to off until the next mode write
        run_blocks(16);
        clear_errors();
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)", 32'd0);
        gpio_write(rf_pkg::ADDR_BRK_MODE, rf_pkg::rf_data_t'(pcs_pkg::BRK_PERIODIC));
        run_blocks(16);
        clear_errors();
        gpio_read_check(rf_pkg::ADDR_ERR_COUNT, "o_gpio_data(err_count)",
                        expected_errors(pcs_pkg::BRK_PERIODIC, 1, 8, 16));

        repeat (2) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
